/* axil_pkg.sv */
`include "dot_settings.svh"

package axil_pkg;

	typedef logic [`DOT_AXI_ADDR_W-1:0] addr_t;
	typedef logic [`DOT_AXI_DATA_W-1:0] data_t;

	typedef enum logic [1:0] {
		RESP_OKAY = 2'b00,
		RESP_EXOKAY = 2'b01,
		RESP_SLVERR = 2'b10,
		RESP_DECERR = 2'b11
	} resp_t;

	typedef struct packed {
		addr_t addr;
	} aw_t;

	typedef struct packed {
		addr_t addr;
	} ar_t;

	typedef struct packed {
		data_t data;
	} w_t;

	typedef struct packed {
		data_t data;
		resp_t resp;
	} r_t;

	typedef struct packed {
		resp_t resp;
	} b_t;

	// Register map.
	localparam addr_t REG_CTRL = 'h000;
	localparam addr_t REG_LENGTH = 'h004;
	localparam addr_t REG_STATUS = 'h008;
	localparam addr_t REG_RESULT = 'h00C;
	localparam addr_t FEAT_BASE = 'h100;
	localparam addr_t WGT_BASE = 'h200;

endpackage

/* dot_engine_ctrl.sv */
`timescale 1ns/1ps
`include "dot_settings.svh"

module dot_engine_ctrl (
	input logic clk,
	input logic i_reset,
	input logic i_awvalid,
	input axil_pkg::aw_t i_aw,
	output logic o_awready,
	input logic i_wvalid,
	input axil_pkg::w_t i_w,
	output logic o_wready,
	output logic o_bvalid,
	output axil_pkg::b_t o_b,
	input logic i_bready,
	input logic i_arvalid,
	input axil_pkg::ar_t i_ar,
	output logic o_arready,
	output logic o_rvalid,
	output axil_pkg::r_t o_r,
	input logic i_rready,
	output logic o_feat_lo_we,
	output logic o_feat_hi_we,
	output logic o_wgt_we,
	output logic [`DOT_IDX_W-1:0] o_wr_idx,
	output axil_pkg::w_t o_wr_data,
	output logic [`DOT_IDX_W-1:0] o_rd_idx,
	output logic o_acc_clear,
	output logic o_acc_valid,
	output logic o_acc_last,
	input logic [`DOT_ACC_W-1:0] i_sum,
	input logic i_done
);

	localparam int unsigned LEN_W = `DOT_IDX_W + 1;
	// Buffer read plus chain latency.
	localparam int unsigned PIPE_DEPTH = 5;
	localparam axil_pkg::addr_t FEAT_MASK = ~axil_pkg::addr_t'(`DOT_DEPTH * 8 - 1);
	localparam axil_pkg::addr_t WGT_MASK = ~axil_pkg::addr_t'(`DOT_DEPTH * 4 - 1);

	logic wr_fire;
	logic rd_fire;
	axil_pkg::addr_t wr_addr;
	logic feat_sel;
	logic wgt_sel;
	logic buf_wr_ok;
	logic start_req;
	logic [LEN_W-1:0] length_q;
	logic busy_q;
	logic busy;
	logic issuing;
	logic issue_last;
	logic [`DOT_IDX_W-1:0] rd_idx_q;
	logic [PIPE_DEPTH-1:0] valid_pipe;
	logic [PIPE_DEPTH-1:0] last_pipe;
	logic bvalid_q;
	logic rvalid_q;
	axil_pkg::data_t rd_data;
	axil_pkg::data_t r_data_q;

	// AW and W are taken together.
	assign o_awready = i_awvalid & i_wvalid & ~bvalid_q;
	assign o_wready = o_awready;
	assign wr_fire = o_awready;
	assign wr_addr = i_aw.addr;

	assign feat_sel = (wr_addr & FEAT_MASK) == axil_pkg::FEAT_BASE;
	assign wgt_sel = (wr_addr & WGT_MASK) == axil_pkg::WGT_BASE;
	assign buf_wr_ok = wr_fire & ~busy_q;

	assign o_feat_lo_we = buf_wr_ok & feat_sel & ~wr_addr[2];
	assign o_feat_hi_we = buf_wr_ok & feat_sel & wr_addr[2];
	assign o_wgt_we = buf_wr_ok & wgt_sel;
	assign o_wr_idx = feat_sel ? wr_addr[3 +: `DOT_IDX_W] : wr_addr[2 +: `DOT_IDX_W];
	assign o_wr_data = i_w;

	assign start_req = buf_wr_ok & (wr_addr == axil_pkg::REG_CTRL) & i_w.data[0];
	assign o_acc_clear = start_req;

	always_ff @(posedge clk) begin
		if (i_reset) begin
			length_q <= LEN_W'(1);
		end else if (buf_wr_ok && wr_addr == axil_pkg::REG_LENGTH) begin
			if (i_w.data == '0) begin
				length_q <= LEN_W'(1);
			end else if (i_w.data > `DOT_AXI_DATA_W'(`DOT_DEPTH)) begin
				length_q <= LEN_W'(`DOT_DEPTH);
			end else begin
				length_q <= i_w.data[LEN_W-1:0];
			end
		end
	end

	// Beat sequencer steps one read index per cycle.
	assign issue_last = issuing & ((LEN_W'(rd_idx_q) + LEN_W'(1)) == length_q);

	always_ff @(posedge clk) begin
		if (i_reset) begin
			busy_q <= 1'b0;
			issuing <= 1'b0;
			rd_idx_q <= '0;
		end else if (start_req) begin
			busy_q <= 1'b1;
			issuing <= 1'b1;
			rd_idx_q <= '0;
		end else begin
			if (issuing) begin
				if (issue_last) begin
					issuing <= 1'b0;
				end else begin
					rd_idx_q <= rd_idx_q + 1'b1;
				end
			end
			if (busy_q && i_done) begin
				busy_q <= 1'b0;
			end
		end
	end

	assign o_rd_idx = rd_idx_q;
	assign busy = busy_q & ~i_done;

	always_ff @(posedge clk) begin
		if (i_reset) begin
			valid_pipe <= '0;
			last_pipe <= '0;
		end else begin
			valid_pipe <= {valid_pipe[PIPE_DEPTH-2:0], issuing};
			last_pipe <= {last_pipe[PIPE_DEPTH-2:0], issue_last};
		end
	end

	assign o_acc_valid = valid_pipe[PIPE_DEPTH-1];
	assign o_acc_last = last_pipe[PIPE_DEPTH-1];

	// Write response.
	always_ff @(posedge clk) begin
		if (i_reset) begin
			bvalid_q <= 1'b0;
		end else if (wr_fire) begin
			bvalid_q <= 1'b1;
		end else if (i_bready) begin
			bvalid_q <= 1'b0;
		end
	end

	assign o_bvalid = bvalid_q;
	assign o_b = '{resp: axil_pkg::RESP_OKAY};

	// Register reads.
	always_comb begin
		case (i_ar.addr)
			axil_pkg::REG_LENGTH: rd_data = `DOT_AXI_DATA_W'(length_q);
			axil_pkg::REG_STATUS: rd_data = `DOT_AXI_DATA_W'({i_done, busy});
			axil_pkg::REG_RESULT: rd_data = `DOT_AXI_DATA_W'(i_sum);
			default: rd_data = '0;
		endcase
	end

	assign o_arready = ~rvalid_q;
	assign rd_fire = i_arvalid & o_arready;

	always_ff @(posedge clk) begin
		if (i_reset) begin
			rvalid_q <= 1'b0;
		end else if (rd_fire) begin
			rvalid_q <= 1'b1;
		end else if (i_rready) begin
			rvalid_q <= 1'b0;
		end
	end

	// Data holds while rvalid waits for rready.
	always_ff @(posedge clk) begin
		if (rd_fire) begin
			r_data_q <= rd_data;
		end
	end

	assign o_rvalid = rvalid_q;
	assign o_r = '{data: r_data_q, resp: axil_pkg::RESP_OKAY};

endmodule

/* dot_engine_top.sv */
`timescale 1ns/1ps
`include "dot_settings.svh"

module dot_engine_top (
	input logic clk,
	input logic i_reset,
	input logic i_awvalid,
	input axil_pkg::aw_t i_aw,
	output logic o_awready,
	input logic i_wvalid,
	input axil_pkg::w_t i_w,
	output logic o_wready,
	output logic o_bvalid,
	output axil_pkg::b_t o_b,
	input logic i_bready,
	input logic i_arvalid,
	input axil_pkg::ar_t i_ar,
	output logic o_arready,
	output logic o_rvalid,
	output axil_pkg::r_t o_r,
	input logic i_rready
);

	logic feat_lo_we;
	logic feat_hi_we;
	logic wgt_we;
	logic [`DOT_IDX_W-1:0] wr_idx;
	axil_pkg::w_t wr_data;
	logic [`DOT_IDX_W-1:0] rd_idx;
	logic acc_clear;
	logic acc_valid;
	logic acc_last;
	logic [`DOT_ACC_W-1:0] sum;
	logic done;
	dot_types_pkg::feature_pair_t feat_lo_rd;
	dot_types_pkg::feature_pair_t feat_hi_rd;
	dot_types_pkg::weight_quad_t wgt_rd;
	dot_types_pkg::beat_t beat;
	logic [`DOT_RES_W-1:0] beat_result;

	dot_engine_ctrl ctrl0 (
		.clk(clk),
		.i_reset(i_reset),
		.i_awvalid(i_awvalid),
		.i_aw(i_aw),
		.o_awready(o_awready),
		.i_wvalid(i_wvalid),
		.i_w(i_w),
		.o_wready(o_wready),
		.o_bvalid(o_bvalid),
		.o_b(o_b),
		.i_bready(i_bready),
		.i_arvalid(i_arvalid),
		.i_ar(i_ar),
		.o_arready(o_arready),
		.o_rvalid(o_rvalid),
		.o_r(o_r),
		.i_rready(i_rready),
		.o_feat_lo_we(feat_lo_we),
		.o_feat_hi_we(feat_hi_we),
		.o_wgt_we(wgt_we),
		.o_wr_idx(wr_idx),
		.o_wr_data(wr_data),
		.o_rd_idx(rd_idx),
		.o_acc_clear(acc_clear),
		.o_acc_valid(acc_valid),
		.o_acc_last(acc_last),
		.i_sum(sum),
		.i_done(done)
	);

	operand_buffer #(.T_ENTRY(dot_types_pkg::feature_pair_t)) feat_lo_buf (
		.clk(clk),
		.i_reset(i_reset),
		.i_wr_en(feat_lo_we),
		.i_wr_idx(wr_idx),
		.i_wr_data(dot_types_pkg::feature_pair_t'(wr_data.data)),
		.i_rd_idx(rd_idx),
		.o_rd_data(feat_lo_rd)
	);

	operand_buffer #(.T_ENTRY(dot_types_pkg::feature_pair_t)) feat_hi_buf (
		.clk(clk),
		.i_reset(i_reset),
		.i_wr_en(feat_hi_we),
		.i_wr_idx(wr_idx),
		.i_wr_data(dot_types_pkg::feature_pair_t'(wr_data.data)),
		.i_rd_idx(rd_idx),
		.o_rd_data(feat_hi_rd)
	);

	operand_buffer #(.T_ENTRY(dot_types_pkg::weight_quad_t)) wgt_buf (
		.clk(clk),
		.i_reset(i_reset),
		.i_wr_en(wgt_we),
		.i_wr_idx(wr_idx),
		.i_wr_data(dot_types_pkg::weight_quad_t'(wr_data.data)),
		.i_rd_idx(rd_idx),
		.o_rd_data(wgt_rd)
	);

	assign beat = '{feat_hi: feat_hi_rd, feat_lo: feat_lo_rd, wgt: wgt_rd};

	dot_product_chain chain0 (
		.clk(clk),
		.i_reset(i_reset),
		.i_beat(beat),
		.o_result(beat_result)
	);

	result_accumulator acc0 (
		.clk(clk),
		.i_reset(i_reset),
		.i_clear(acc_clear),
		.i_valid(acc_valid),
		.i_last(acc_last),
		.i_beat_result(beat_result),
		.o_sum(sum),
		.o_done(done)
	);

endmodule

/* dot_product_chain.sv */
`timescale 1ns/1ps
`include "dot_settings.svh"

module dot_product_chain (
	input logic clk,
	input logic i_reset,
	input dot_types_pkg::beat_t i_beat,
	output logic [`DOT_RES_W-1:0] o_result
);

	dot_types_pkg::beat_t s1_beat;
	dot_types_pkg::feature_pair_t s2_feat_hi;
	dot_types_pkg::weight_t s2_wgt_2;
	dot_types_pkg::weight_t s2_wgt_3;
	dot_types_pkg::beat_result_t chain_0;
	dot_types_pkg::beat_result_t result_1;

	// Lanes 2/3 get one extra stage to meet pair 0's chain output.
	always_ff @(posedge clk) begin
		if (i_reset) begin
			s1_beat <= '0;
			s2_feat_hi <= '0;
			s2_wgt_2 <= '0;
			s2_wgt_3 <= '0;
		end else begin
			s1_beat <= i_beat;
			s2_feat_hi <= s1_beat.feat_hi;
			s2_wgt_2 <= s1_beat.wgt.lane[2];
			s2_wgt_3 <= s1_beat.wgt.lane[3];
		end
	end

	dsp_mac_pair pair_0 (
		.clk(clk),
		.i_reset(i_reset),
		.i_ax(s1_beat.feat_lo.lo),
		.i_bx(s1_beat.feat_lo.hi),
		.i_ay(s1_beat.wgt.lane[0]),
		.i_by(s1_beat.wgt.lane[1]),
		.i_chain('0),
		.o_result(chain_0)
	);

	dsp_mac_pair pair_1 (
		.clk(clk),
		.i_reset(i_reset),
		.i_ax(s2_feat_hi.lo),
		.i_bx(s2_feat_hi.hi),
		.i_ay(s2_wgt_2),
		.i_by(s2_wgt_3),
		.i_chain(chain_0),
		.o_result(result_1)
	);

	assign o_result = result_1;

endmodule

/* dot_settings.svh */
`ifndef DOT_SETTINGS_SVH
`define DOT_SETTINGS_SVH

// Lane count of the multiply pipeline.
`define DOT_LANES 4

// Unsigned operand widths.
`define DOT_FEAT_W 16
`define DOT_WGT_W 8

// One beat's chained result, and the wrapping accumulator.
`define DOT_RES_W 24
`define DOT_ACC_W 32

// Operand buffer depth in beats.
`define DOT_DEPTH 16
`define DOT_IDX_W 4

// AXI4-Lite bus widths.
`define DOT_AXI_ADDR_W 12
`define DOT_AXI_DATA_W 32

`endif

/* dot_types_pkg.sv */
`include "dot_settings.svh"

package dot_types_pkg;

	typedef logic [`DOT_FEAT_W-1:0] feature_t;
	typedef logic [`DOT_WGT_W-1:0] weight_t;
	typedef logic [`DOT_RES_W-1:0] beat_result_t;

	// Lower lane sits in the low half.
	typedef struct packed {
		feature_t hi;
		feature_t lo;
	} feature_pair_t;

	// Lane 0 in the low byte.
	typedef struct packed {
		weight_t [`DOT_LANES-1:0] lane;
	} weight_quad_t;

	// Operands of one beat in 96 bits.
	typedef struct packed {
		feature_pair_t feat_hi;
		feature_pair_t feat_lo;
		weight_quad_t wgt;
	} beat_t;

endpackage

/* dsp_mac_pair.sv */
`timescale 1ns/1ps
`include "dot_settings.svh"

module dsp_mac_pair (
	input logic clk,
	input logic i_reset,
	input dot_types_pkg::feature_t i_ax,
	input dot_types_pkg::feature_t i_bx,
	input dot_types_pkg::weight_t i_ay,
	input dot_types_pkg::weight_t i_by,
	input dot_types_pkg::beat_result_t i_chain,
	output dot_types_pkg::beat_result_t o_result
);

	dot_types_pkg::feature_t ax_q;
	dot_types_pkg::feature_t bx_q;
	dot_types_pkg::weight_t ay_q;
	dot_types_pkg::weight_t by_q;
	logic [`DOT_RES_W-1:0] prod_a;
	logic [`DOT_RES_W-1:0] prod_b;

	// A 16x8 product fits the result width exactly.
	assign prod_a = ax_q * ay_q;
	assign prod_b = bx_q * by_q;

	always_ff @(posedge clk) begin
		if (i_reset) begin
			ax_q <= '0;
			bx_q <= '0;
			ay_q <= '0;
			by_q <= '0;
			o_result <= '0;
		end else begin
			ax_q <= i_ax;
			bx_q <= i_bx;
			ay_q <= i_ay;
			by_q <= i_by;
			// Sum wraps at 24 bits like the hard DSP.
			o_result <= prod_a + prod_b + i_chain;
		end
	end

endmodule

/* operand_buffer.sv */
`timescale 1ns/1ps
`include "dot_settings.svh"

module operand_buffer #(
	parameter type T_ENTRY = logic [31:0]
) (
	input logic clk,
	input logic i_reset,
	input logic i_wr_en,
	input logic [`DOT_IDX_W-1:0] i_wr_idx,
	input T_ENTRY i_wr_data,
	input logic [`DOT_IDX_W-1:0] i_rd_idx,
	output T_ENTRY o_rd_data
);

	T_ENTRY mem [`DOT_DEPTH];

	always_ff @(posedge clk) begin
		if (i_wr_en) begin
			mem[i_wr_idx] <= i_wr_data;
		end
	end

	// Registered read port.
	always_ff @(posedge clk) begin
		if (i_reset) begin
			o_rd_data <= '0;
		end else begin
			o_rd_data <= mem[i_rd_idx];
		end
	end

endmodule

/* result_accumulator.sv */
`timescale 1ns/1ps
`include "dot_settings.svh"

module result_accumulator (
	input logic clk,
	input logic i_reset,
	input logic i_clear,
	input logic i_valid,
	input logic i_last,
	input logic [`DOT_RES_W-1:0] i_beat_result,
	output logic [`DOT_ACC_W-1:0] o_sum,
	output logic o_done
);

	logic [`DOT_ACC_W-1:0] beat_ext;

	assign beat_ext = `DOT_ACC_W'(i_beat_result);

	always_ff @(posedge clk) begin
		if (i_reset || i_clear) begin
			o_sum <= '0;
			o_done <= 1'b0;
		end else if (i_valid) begin
			// Wraps at 32 bits.
			o_sum <= o_sum + beat_ext;
			if (i_last) begin
				o_done <= 1'b1;
			end
		end
	end

endmodule

/* run_sim.sh */
#!/bin/sh
# Builds the testbench with Verilator and runs it.
# The exit status of the simulation is the result.
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
	-f src.f \
	--top-module tb_dot_engine

./obj_dir/Vtb_dot_engine

/* src.f */
+incdir+.
dot_types_pkg.sv
axil_pkg.sv
operand_buffer.sv
dsp_mac_pair.sv
dot_product_chain.sv
result_accumulator.sv
dot_engine_ctrl.sv
dot_engine_top.sv
tb_dot_engine.sv

/* tb_dot_engine.sv */
`timescale 1ns/1ps
`include "dot_settings.svh"

module tb_dot_engine;

	localparam int NUM_CASES = 5;
	localparam logic [1:0] MODE_RAMP = 2'd0;
	localparam logic [1:0] MODE_RANDOM = 2'd1;
	localparam logic [1:0] MODE_MAX = 2'd2;

	// One row of the case table.
	typedef struct packed {
		logic [8*12-1:0] name;
		logic [4:0] length;
		logic [1:0] mode;
		logic [3:0] stall;
		logic rerun;
	} case_t;

	logic clk;
	logic reset;
	logic awvalid;
	axil_pkg::aw_t aw;
	logic awready;
	logic wvalid;
	axil_pkg::w_t w;
	logic wready;
	logic bvalid;
	axil_pkg::b_t b;
	logic bready;
	logic arvalid;
	axil_pkg::ar_t ar;
	logic arready;
	logic rvalid;
	axil_pkg::r_t r;
	logic rready;

	case_t cases [NUM_CASES];
	logic [`DOT_FEAT_W-1:0] feat [`DOT_DEPTH][`DOT_LANES];
	logic [`DOT_WGT_W-1:0] wgt [`DOT_DEPTH][`DOT_LANES];
	int seed;
	int cycles;
	int limit;

	dot_engine_top dut0 (
		.clk(clk),
		.i_reset(reset),
		.i_awvalid(awvalid),
		.i_aw(aw),
		.o_awready(awready),
		.i_wvalid(wvalid),
		.i_w(w),
		.o_wready(wready),
		.o_bvalid(bvalid),
		.o_b(b),
		.i_bready(bready),
		.i_arvalid(arvalid),
		.i_ar(ar),
		.o_arready(arready),
		.o_rvalid(rvalid),
		.o_r(r),
		.i_rready(rready)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic check_value(input string test, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			$display("Fail %s expected %h actual %h", test, expected, actual);
			$display("sim failed");
			$fatal(1, "%s mismatch", test);
		end
	endtask

	task automatic bus_write(input axil_pkg::addr_t addr, input logic [31:0] data);
		@(posedge clk);
		awvalid <= 1'b1;
		wvalid <= 1'b1;
		aw <= '{addr: addr};
		w <= '{data: data};
		@(negedge clk);
		while (!(awready && wready)) begin
			@(negedge clk);
		end
		@(posedge clk);
		awvalid <= 1'b0;
		wvalid <= 1'b0;
		@(negedge clk);
		while (!bvalid) begin
			@(negedge clk);
		end
		check_value("write_resp", 32'(axil_pkg::RESP_OKAY), 32'(b.resp));
	endtask

	// Holds rready low for stall cycles once rvalid is up.
	task automatic bus_read(input axil_pkg::addr_t addr, input int stall,
			output logic [31:0] data);
		axil_pkg::r_t first;
		int k;
		@(posedge clk);
		arvalid <= 1'b1;
		ar <= '{addr: addr};
		@(negedge clk);
		while (!arready) begin
			@(negedge clk);
		end
		@(posedge clk);
		arvalid <= 1'b0;
		@(negedge clk);
		while (!rvalid) begin
			@(negedge clk);
		end
		first = r;
		for (k = 0; k < stall; k++) begin
			@(negedge clk);
			check_value("rvalid_hold", 32'd1, 32'(rvalid));
			check_value("rdata_hold", first.data, r.data);
		end
		check_value("read_resp", 32'(axil_pkg::RESP_OKAY), 32'(first.resp));
		@(posedge clk);
		rready <= 1'b1;
		@(posedge clk);
		rready <= 1'b0;
		data = first.data;
	endtask

	task automatic wait_for_done(input int stall);
		logic [31:0] status;
		status = '0;
		while (!status[1]) begin
			bus_read(axil_pkg::REG_STATUS, stall, status);
		end
		check_value("status_done", 32'd2, status);
	endtask

	task automatic fill_operands(input logic [1:0] mode, input int len);
		for (int i = 0; i < len; i++) begin
			for (int l = 0; l < `DOT_LANES; l++) begin
				case (mode)
					MODE_RAMP: begin
						feat[i][l] = `DOT_FEAT_W'(1000 * i + 100 * l + 7);
						wgt[i][l] = `DOT_WGT_W'(8 * i + l + 1);
					end
					MODE_RANDOM: begin
						feat[i][l] = `DOT_FEAT_W'($random(seed));
						wgt[i][l] = `DOT_WGT_W'($random(seed));
					end
					default: begin
						feat[i][l] = '1;
						wgt[i][l] = '1;
					end
				endcase
			end
		end
	endtask

	task automatic load_buffers(input int len);
		for (int i = 0; i < len; i++) begin
			bus_write(axil_pkg::FEAT_BASE + axil_pkg::addr_t'(8 * i),
				{feat[i][1], feat[i][0]});
			bus_write(axil_pkg::FEAT_BASE + axil_pkg::addr_t'(8 * i + 4),
				{feat[i][3], feat[i][2]});
			bus_write(axil_pkg::WGT_BASE + axil_pkg::addr_t'(4 * i),
				{wgt[i][3], wgt[i][2], wgt[i][1], wgt[i][0]});
		end
	endtask

	function automatic logic [31:0] model_result(input int len);
		logic [31:0] acc;
		logic [31:0] beat_sum;
		acc = '0;
		for (int i = 0; i < len; i++) begin
			beat_sum = '0;
			for (int l = 0; l < `DOT_LANES; l++) begin
				beat_sum = beat_sum + 32'(feat[i][l]) * 32'(wgt[i][l]);
			end
			// Only the low 24 bits of a beat reach the accumulator.
			acc = acc + {8'h00, beat_sum[23:0]};
		end
		return acc;
	endfunction

	function automatic int timeout_cycles();
		int total;
		total = 0;
		for (int k = 0; k < NUM_CASES; k++) begin
			total = total + int'(cases[k].length) * 20 + 200;
		end
		return total;
	endfunction

	task automatic run_case(input case_t tc);
		string name;
		logic [31:0] expected;
		logic [31:0] data;
		int len;
		name = string'(tc.name);
		len = int'(tc.length);
		fill_operands(tc.mode, len);
		expected = model_result(len);
		load_buffers(len);
		bus_write(axil_pkg::REG_LENGTH, 32'(len));
		bus_write(axil_pkg::REG_CTRL, 32'd1);
		bus_read(axil_pkg::REG_STATUS, 0, data);
		check_value({name, "_busy"}, 32'd1, data);
		if (tc.rerun) begin
			// All three land while busy.
			bus_write(axil_pkg::REG_CTRL, 32'd1);
			bus_write(axil_pkg::FEAT_BASE, 32'hFFFF_FFFF);
			bus_write(axil_pkg::REG_LENGTH, 32'd2);
		end
		wait_for_done(int'(tc.stall));
		bus_read(axil_pkg::REG_RESULT, int'(tc.stall), data);
		check_value(name, expected, data);
		if (tc.rerun) begin
			bus_read(axil_pkg::REG_LENGTH, 0, data);
			check_value({name, "_length"}, 32'(len), data);
			bus_write(axil_pkg::REG_CTRL, 32'd1);
			bus_read(axil_pkg::REG_STATUS, 0, data);
			check_value({name, "_restart"}, 32'd1, data);
			wait_for_done(0);
			bus_read(axil_pkg::REG_RESULT, 0, data);
			check_value({name, "_rerun"}, expected, data);
		end
	endtask

	initial begin
		logic [31:0] data;
		cases[0] = '{name: "ramp_single", length: 5'd1, mode: MODE_RAMP,
			stall: 4'd0, rerun: 1'b0};
		cases[1] = '{name: "random_full", length: 5'd16, mode: MODE_RANDOM,
			stall: 4'd0, rerun: 1'b0};
		cases[2] = '{name: "max_truncate", length: 5'd4, mode: MODE_MAX,
			stall: 4'd0, rerun: 1'b0};
		cases[3] = '{name: "back_to_back", length: 5'd10, mode: MODE_RANDOM,
			stall: 4'd0, rerun: 1'b1};
		cases[4] = '{name: "read_stall", length: 5'd5, mode: MODE_RAMP,
			stall: 4'd6, rerun: 1'b0};
		seed = 11328;
		reset = 1'b1;
		awvalid = 1'b0;
		aw = '0;
		wvalid = 1'b0;
		w = '0;
		bready = 1'b1;
		arvalid = 1'b0;
		ar = '0;
		rready = 1'b0;
		repeat (5) @(posedge clk);
		reset <= 1'b0;

		// Register defaults and LENGTH write back.
		bus_read(axil_pkg::REG_STATUS, 0, data);
		check_value("reset_status", 32'd0, data);
		bus_read(axil_pkg::REG_LENGTH, 0, data);
		check_value("reset_length", 32'd1, data);
		bus_write(axil_pkg::REG_LENGTH, 32'd7);
		bus_read(axil_pkg::REG_LENGTH, 0, data);
		check_value("length_write", 32'd7, data);
		bus_write(axil_pkg::REG_LENGTH, 32'd0);
		bus_read(axil_pkg::REG_LENGTH, 0, data);
		check_value("length_zero", 32'd1, data);

		// Buffer windows read as zero even when filled.
		bus_write(axil_pkg::FEAT_BASE, 32'hA5A5_5A5A);
		bus_read(axil_pkg::FEAT_BASE, 0, data);
		check_value("feat_base_read", 32'd0, data);
		bus_write(axil_pkg::WGT_BASE, 32'h0403_0201);
		bus_read(axil_pkg::WGT_BASE, 0, data);
		check_value("wgt_base_read", 32'd0, data);

		for (int k = 0; k < NUM_CASES; k++) begin
			run_case(cases[k]);
		end
		$display("sim passed");
		$finish;
	end

	initial begin
		cycles = 0;
		@(posedge clk);
		limit = timeout_cycles();
		while (cycles < limit) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout waiting for done");
		$display("sim failed");
		$fatal(1, "cycle limit of %0d reached", limit);
	end

endmodule
